// File: logic/predecode_pkg.sv
//==========================================================================
// shared opcode and register constants, instruction and offset types,
// and the packed result structs of the RISC-V predecoder
//==========================================================================

package predecode_pkg;

    //======================================================================
    // major opcodes, bits [6:0] of a 32-bit word
    //======================================================================
    localparam logic [6:0] OP_JAL      = 7'b1101111;  // jal
    localparam logic [6:0] OP_JALR     = 7'b1100111;  // jalr, funct3 must be 0
    localparam logic [6:0] OP_BRANCH   = 7'b1100011;  // beq/bne/blt/bge/bltu/bgeu
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;  // auipc
    localparam logic [6:0] OP_LOAD     = 7'b0000011;  // lb .. lwu
    localparam logic [6:0] OP_LOAD_FP  = 7'b0000111;  // flh/flw/fld
    localparam logic [6:0] OP_STORE    = 7'b0100011;  // sb .. sd
    localparam logic [6:0] OP_STORE_FP = 7'b0100111;  // fsh/fsw/fsd

    //======================================================================
    // register numbers
    //======================================================================
    localparam logic [4:0] REG_ZERO = 5'd0;  // x0
    localparam logic [4:0] REG_RA   = 5'd1;  // x1, primary link reg
    localparam logic [4:0] REG_T0   = 5'd5;  // x5, alternate link reg

    // one fetched word; a compressed inst sits in bits [15:0]
    typedef logic [31:0] pd_inst_t;

    // sign-extended branch offset, sized for the jal immediate
    typedef logic signed [20:0] pd_offset_t;

    // control-flow class and return-stack hints
    typedef struct packed {
        logic jal;       // jal or c.j
        logic jalr;      // jalr, c.jr, c.jalr
        logic con_br;    // conditional branch
        logic ab_br;     // absolute jump, jal or c.j
        logic chgflw;    // unconditional change of flow
        logic branch;    // any branch or jump
        logic pc_oper;   // reads the pc
        logic auipc;     // auipc
        logic dst_vld;   // writes a link reg
        logic pcall;     // ras push
        logic preturn;   // ras pop
        logic ind_br;    // other indirect jump
    } pd_flow_t;

    // memory access class
    typedef struct packed {
        logic ld;        // standard load
        logic st;        // standard store
    } pd_mem_t;

    // full predecode result, 35 bits
    typedef struct packed {
        pd_flow_t   flow;
        pd_mem_t    mem;
        pd_offset_t offset;
    } pd_result_t;

endpackage

// File: logic/predecode_top.sv
//==========================================================================
// predecoder top level, handshake control plus three decoders
//==========================================================================

module predecode_top import predecode_pkg::*; #(
    parameter bit RVC_EN = 1'b1              // compressed decode on
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_req,               // instruction side
    output logic       in_ack,
    input  pd_inst_t   inst,
    output logic       out_req,              // result side
    input  logic       out_ack,
    output pd_result_t result
);

    pd_inst_t   cur_inst;                    // captured word
    pd_flow_t   flow;
    pd_mem_t    mem;
    pd_offset_t offset;

    predecode_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .inst     (inst),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .cur_inst (cur_inst),
        .flow     (flow),
        .mem      (mem),
        .offset   (offset),
        .result   (result)
    );

    pd_flow_decode #(.RVC_EN(RVC_EN)) u_flow (.cur_inst(cur_inst), .flow(flow));

    pd_offset_gen #(.RVC_EN(RVC_EN)) u_offset (.cur_inst(cur_inst), .offset(offset));

    pd_mem_decode #(.RVC_EN(RVC_EN)) u_mem (.cur_inst(cur_inst), .mem(mem));

endmodule

// File: logic/predecode_ctrl.sv
//==========================================================================
// four-phase handshake FSM with instruction and result registers
//==========================================================================

module predecode_ctrl import predecode_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_req,
    output logic       in_ack,
    input  pd_inst_t   inst,
    output logic       out_req,
    input  logic       out_ack,
    output pd_inst_t   cur_inst,             // to the decoders
    input  pd_flow_t   flow,                 // decoder returns
    input  pd_mem_t    mem,
    input  pd_offset_t offset,
    output pd_result_t result
);

    typedef enum logic [1:0] {
        ST_IDLE,                             // output side free
        ST_CAPT,                             // word captured, decoding
        ST_PRES,                             // out_req high
        ST_DRAIN                             // wait for out_ack low
    } state_t;

    state_t state;
    logic   accept;                          // take a new word this edge

    // all of in_ack, out_req and out_ack must be low
    assign accept = in_req && !in_ack && !out_req && !out_ack &&
                    (state == ST_IDLE || state == ST_DRAIN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
            result  <= '0;
        end else begin
            if (accept) begin
                in_ack <= 1'b1;              // same edge as capture
            end else if (!in_req) begin
                in_ack <= 1'b0;              // partner dropped its req
            end
            case (state)
                ST_IDLE: begin
                    if (accept) state <= ST_CAPT;
                end
                ST_CAPT: begin
                    result.flow   <= flow;   // decoders settled on cur_inst
                    result.mem    <= mem;
                    result.offset <= offset;
                    out_req       <= 1'b1;
                    state         <= ST_PRES;
                end
                ST_PRES: begin
                    if (out_ack) begin       // result held until here
                        out_req <= 1'b0;
                        state   <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (accept) state <= ST_CAPT;
                    else if (!out_ack) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload reg, loaded on accept only
    always_ff @(posedge clk) begin
        if (accept) cur_inst <= inst;
    end

endmodule

// File: logic/pd_flow_decode.sv
//==========================================================================
// control-flow classification and return-stack hints
//==========================================================================

module pd_flow_decode import predecode_pkg::*; #(
    parameter bit RVC_EN = 1'b1
) (
    input  pd_inst_t cur_inst,
    output pd_flow_t flow
);

    logic [4:0] rd;                          // rd, also rs1 of c.jr/c.jalr
    logic [4:0] rs1;
    logic       rd_link;                     // rd is x1 or x5
    logic       rs1_link;
    logic       is_jal;                      // 32-bit forms
    logic       is_jalr;
    logic       is_br;
    logic       is_auipc;
    logic       c_j;                         // 16-bit forms
    logic       c_jr;
    logic       c_jalr;
    logic       c_br;
    logic       jalr_fam;

    assign rd       = cur_inst[11:7];
    assign rs1      = cur_inst[19:15];
    assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
    assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);

    //======================================================================
    // format match
    //======================================================================
    assign is_jal   = (cur_inst[6:0] == OP_JAL);
    assign is_jalr  = (cur_inst[6:0] == OP_JALR) && (cur_inst[14:12] == 3'b000);
    assign is_br    = (cur_inst[6:0] == OP_BRANCH);
    assign is_auipc = (cur_inst[6:0] == OP_AUIPC);

    // compressed, quadrant in [1:0] never equals 2'b11
    assign c_j    = RVC_EN && ({cur_inst[15:13], cur_inst[1:0]} == 5'b101_01);
    assign c_br   = RVC_EN && ({cur_inst[15:14], cur_inst[1:0]} == 4'b11_01);  // beqz/bnez
    assign c_jr   = RVC_EN && ({cur_inst[15:12], cur_inst[6:0]} == 11'b1000_00000_10) &&
                    (rd != REG_ZERO);
    assign c_jalr = RVC_EN && ({cur_inst[15:12], cur_inst[6:0]} == 11'b1001_00000_10) &&
                    (rd != REG_ZERO);    // rs1=0 would be c.ebreak

    assign jalr_fam = is_jalr || c_jr || c_jalr;

    //======================================================================
    // class flags
    //======================================================================
    assign flow.jal     = is_jal || c_j;
    assign flow.jalr    = jalr_fam;
    assign flow.ab_br   = is_jal || c_j;
    assign flow.con_br  = is_br || c_br;
    assign flow.chgflw  = jalr_fam || flow.ab_br;               // no con_br here
    assign flow.branch  = jalr_fam || flow.ab_br || flow.con_br;
    assign flow.auipc   = is_auipc;
    assign flow.pc_oper = flow.branch || is_auipc;
    assign flow.dst_vld = ((is_jal || is_jalr) && (rd != REG_ZERO)) || c_jalr;  // c.jalr links x1

    //======================================================================
    // ras hints
    //======================================================================
    assign flow.pcall   = ((is_jal || is_jalr) && rd_link) || c_jalr;
    assign flow.preturn = (is_jalr && rs1_link && (rs1 != rd) &&
                           (cur_inst[31:20] == 12'd0)) ||       // plain ret form
                          (c_jr && rd_link) ||                  // c.jr x1/x5
                          (c_jalr && (rd == REG_T0));           // c.jalr x5, rd is x1
    assign flow.ind_br  = jalr_fam && !flow.preturn;            // rest of the family

endmodule

// File: logic/pd_offset_gen.sv
//==========================================================================
// branch immediate extraction, five formats, sign-extended to 21 bits
//==========================================================================

module pd_offset_gen import predecode_pkg::*; #(
    parameter bit RVC_EN = 1'b1
) (
    input  pd_inst_t   cur_inst,
    output pd_offset_t offset
);

    pd_offset_t imm_j;                       // jal
    pd_offset_t imm_i;                       // jalr
    pd_offset_t imm_b;                       // cond branch
    pd_offset_t imm_cj;                      // c.j
    pd_offset_t imm_cb;                      // c.beqz/c.bnez
    logic       c_j;
    logic       c_br;

    assign c_j  = RVC_EN && ({cur_inst[15:13], cur_inst[1:0]} == 5'b101_01);
    assign c_br = RVC_EN && ({cur_inst[15:14], cur_inst[1:0]} == 4'b11_01);

    assign imm_j  = {cur_inst[31], cur_inst[19:12], cur_inst[20], cur_inst[30:21], 1'b0};
    assign imm_i  = {{9{cur_inst[31]}}, cur_inst[31:20]};
    assign imm_b  = {{9{cur_inst[31]}}, cur_inst[7], cur_inst[30:25],
                     cur_inst[11:8], 1'b0};

    // scrambled 16-bit layouts
    assign imm_cj = {{10{cur_inst[12]}}, cur_inst[8], cur_inst[10:9], cur_inst[6],
                     cur_inst[7], cur_inst[2], cur_inst[11], cur_inst[5:3], 1'b0};
    assign imm_cb = {{13{cur_inst[12]}}, cur_inst[6:5], cur_inst[2],
                     cur_inst[11:10], cur_inst[4:3], 1'b0};

    // formats are exclusive, so order does not matter
    always_comb begin
        if (cur_inst[6:0] == OP_JAL) begin
            offset = imm_j;
        end else if (cur_inst[6:0] == OP_JALR) begin
            offset = imm_i;                  // any funct3
        end else if (cur_inst[6:0] == OP_BRANCH) begin
            offset = imm_b;
        end else if (c_j) begin
            offset = imm_cj;
        end else if (c_br) begin
            offset = imm_cb;
        end else begin
            offset = '0;                     // incl c.jr/c.jalr, reg target
        end
    end

endmodule

// File: logic/pd_mem_decode.sv
//==========================================================================
// standard load and store classification
//==========================================================================

module pd_mem_decode import predecode_pkg::*; #(
    parameter bit RVC_EN = 1'b1
) (
    input  pd_inst_t cur_inst,
    output pd_mem_t  mem
);

    logic [2:0] f3;                          // 32-bit funct3
    logic [2:0] cf3;                         // 16-bit funct3
    logic       q0;                          // compressed quadrant 0
    logic       q2;                          // compressed quadrant 2
    logic       rd_nz;

    assign f3    = cur_inst[14:12];
    assign cf3   = cur_inst[15:13];
    assign q0    = RVC_EN && (cur_inst[1:0] == 2'b00);
    assign q2    = RVC_EN && (cur_inst[1:0] == 2'b10);
    assign rd_nz = (cur_inst[11:7] != REG_ZERO);

    assign mem.ld = ((cur_inst[6:0] == OP_LOAD) && (f3 != 3'b111)) ||  // lb .. lwu
                    (cur_inst[6:0] == OP_LOAD_FP) ||
                    (q0 && (cf3 == 3'b001)) ||                          // c.fld
                    (q0 && (cf3 == 3'b010)) ||                          // c.lw
                    (q0 && (cf3 == 3'b011)) ||                          // c.ld
                    (q2 && (cf3 == 3'b001)) ||                          // c.fldsp
                    (q2 && (cf3 == 3'b010) && rd_nz) ||                 // c.lwsp
                    (q2 && (cf3 == 3'b011) && rd_nz);                   // c.ldsp

    assign mem.st = ((cur_inst[6:0] == OP_STORE) && !f3[2]) ||          // sb .. sd
                    (cur_inst[6:0] == OP_STORE_FP) ||
                    (q0 && (cf3 == 3'b101)) ||                          // c.fsd
                    (q0 && (cf3 == 3'b110)) ||                          // c.sw
                    (q0 && (cf3 == 3'b111)) ||                          // c.sd
                    (q2 && (cf3 == 3'b101)) ||                          // c.fsdsp
                    (q2 && (cf3 == 3'b110)) ||                          // c.swsp
                    (q2 && (cf3 == 3'b111));                            // c.sdsp

endmodule

// File: test/predecode_asserts.sv
//==========================================================================
// reference predecode model and concurrent checks, bound to predecode_top
//==========================================================================

module predecode_asserts import predecode_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       in_req,
    input logic       in_ack,
    input pd_inst_t   inst,
    input logic       out_req,
    input logic       out_ack,
    input pd_result_t result
);

    logic       err_seen = 1'b0;             // watched by the testbench
    pd_flow_t   exp_flow;
    pd_mem_t    exp_mem;
    pd_offset_t exp_off;
    logic       pair_seen;                   // in_req and in_ack already seen together

    function automatic pd_flow_t ref_flow(pd_inst_t w);
        pd_flow_t   f;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic       j32, jr32, cj, cb, cjr, cjalr, fam;
        rd    = w[11:7];
        rs1   = w[19:15];
        j32   = (w[6:0] == OP_JAL);
        jr32  = (w[6:0] == OP_JALR) && (w[14:12] == 3'd0);
        cj    = (w[1:0] == 2'b01) && (w[15:13] == 3'b101);
        cb    = (w[1:0] == 2'b01) && (w[15:14] == 2'b11);
        cjr   = (w[1:0] == 2'b10) && (w[15:12] == 4'b1000) && (w[6:2] == 5'd0) && (rd != 5'd0);
        cjalr = (w[1:0] == 2'b10) && (w[15:12] == 4'b1001) && (w[6:2] == 5'd0) && (rd != 5'd0);
        fam   = jr32 || cjr || cjalr;
        f.jal     = j32 || cj;
        f.jalr    = fam;
        f.ab_br   = j32 || cj;
        f.con_br  = (w[6:0] == OP_BRANCH) || cb;
        f.chgflw  = fam || f.ab_br;
        f.branch  = fam || f.ab_br || f.con_br;
        f.auipc   = (w[6:0] == OP_AUIPC);
        f.pc_oper = f.branch || f.auipc;
        f.dst_vld = ((j32 || jr32) && rd != 5'd0) || cjalr;
        f.pcall   = ((j32 || jr32) && (rd == 5'd1 || rd == 5'd5)) || cjalr;
        f.preturn = (jr32 && (rs1 == 5'd1 || rs1 == 5'd5) && rs1 != rd && w[31:20] == 12'd0)
                    || (cjr && (rd == 5'd1 || rd == 5'd5)) || (cjalr && rd == 5'd5);
        f.ind_br  = fam && !f.preturn;
        return f;
    endfunction

    function automatic pd_offset_t ref_offset(pd_inst_t w);
        logic [20:0] im;
        im = '0;
        if (w[6:0] == OP_JAL) begin
            im = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:0] == OP_JALR) begin
            im = {{9{w[31]}}, w[31:20]};
        end else if (w[6:0] == OP_BRANCH) begin
            im = {{8{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else if (w[1:0] == 2'b01 && w[15:13] == 3'b101) begin
            im[11:0] = {w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
            im[20:12] = {9{w[12]}};          // c.j
        end else if (w[1:0] == 2'b01 && w[15:14] == 2'b11) begin
            im[8:0]  = {w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};
            im[20:9] = {12{w[12]}};          // c.beqz/c.bnez
        end
        return im;
    endfunction

    function automatic pd_mem_t ref_mem(pd_inst_t w);
        pd_mem_t m;
        m = '0;
        case (w[1:0])
            2'b11: begin
                m.ld = (w[6:0] == OP_LOAD && w[14:12] <= 3'd6) || w[6:0] == OP_LOAD_FP;
                m.st = (w[6:0] == OP_STORE && w[14:12] <= 3'd3) || w[6:0] == OP_STORE_FP;
            end
            2'b00: begin
                m.ld = (w[15:13] inside {3'd1, 3'd2, 3'd3});
                m.st = (w[15:13] inside {3'd5, 3'd6, 3'd7});
            end
            2'b10: begin
                m.ld = (w[15:13] == 3'd1) || (w[15:13] inside {3'd2, 3'd3} && w[11:7] != 5'd0);
                m.st = (w[15:13] inside {3'd5, 3'd6, 3'd7});
            end
            default: m = '0;                 // quadrant 1 has no memory ops
        endcase
        return m;
    endfunction

    // raise the flag the testbench watches
    task automatic report_fail(string msg);
        $error("%s", msg);
        err_seen = 1'b1;
    endtask

    // expected result of the word seen on the first in_req/in_ack overlap
    always_ff @(posedge clk) begin
        pair_seen <= rst_n && in_req && in_ack;
        if (rst_n && in_req && in_ack && !pair_seen) begin
            exp_flow <= ref_flow(inst);
            exp_mem  <= ref_mem(inst);
            exp_off  <= ref_offset(inst);
        end
    end

    //======================================================================
    // handshake
    //======================================================================
    a_reset: assert property (@(posedge clk) !rst_n |=> !in_ack && !out_req && result == '0)
        else report_fail($sformatf("Fail %0t in_ack/out_req/result expected 0/0/0 got %b/%b/%h",
            $time, $sampled(in_ack), $sampled(out_req), $sampled(result)));
    a_accept: assert property (@(posedge clk) disable iff (!rst_n)
        in_req && !in_ack && !out_req && !out_ack |=> in_ack)
        else report_fail($sformatf("Fail %0t in_ack expected 1 got %b", $time, $sampled(in_ack)));
    a_no_early_ack: assert property (@(posedge clk) disable iff (!rst_n)
        in_req && !in_ack && (out_req || out_ack) |=> !in_ack)
        else report_fail($sformatf("Fail %0t in_ack expected 0 got %b", $time, $sampled(in_ack)));
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n) in_ack && !in_req |=> !in_ack)
        else report_fail($sformatf("Fail %0t in_ack expected 0 got %b", $time, $sampled(in_ack)));
    a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |=> $rose(out_req))
        else report_fail($sformatf("Fail %0t out_req expected 1 got %b", $time,
            $sampled(out_req)));
    a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && out_ack |=> !out_req)
        else report_fail($sformatf("Fail %0t out_req expected 0 got %b", $time,
            $sampled(out_req)));
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(result))
        else report_fail($sformatf("Fail %0t result expected %h got %h", $time,
            $past(result), $sampled(result)));

    //======================================================================
    // result contents at out_req rise
    //======================================================================
    a_flow: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> result.flow == exp_flow)
        else report_fail($sformatf("Fail %0t result.flow expected %h got %h", $time,
            exp_flow, $sampled(result.flow)));
    a_mem: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> result.mem == exp_mem)
        else report_fail($sformatf("Fail %0t result.mem expected %b got %b", $time,
            exp_mem, $sampled(result.mem)));
    a_off: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> result.offset == exp_off)
        else report_fail($sformatf("Fail %0t result.offset expected %h got %h", $time,
            exp_off, $sampled(result.offset)));

endmodule

bind predecode_top predecode_asserts u_asserts (.*);

// File: test/predecode_tb.sv
//==========================================================================
// predecoder testbench: clock, reset, four-phase stimulus, watchdog
//==========================================================================

module predecode_tb import predecode_pkg::*; ();

    localparam int N_TXN = 2000;             // instructions sent

    logic       clk;
    logic       rst_n;
    logic       in_req;
    logic       in_ack;
    pd_inst_t   inst;
    logic       out_req;
    logic       out_ack;
    pd_result_t result;
    integer     seed;
    int         n_done;                      // results taken

    predecode_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // link-ish regs most of the time
    function automatic logic [4:0] pick_reg();
        case ($unsigned($random(seed)) % 5)
            0: return 5'd0;
            1: return 5'd1;
            2: return 5'd5;
            default: return $random(seed);
        endcase
    endfunction

    function automatic pd_inst_t make_word();
        pd_inst_t w;
        w = $random(seed);
        if ($random(seed) & 1) return w;     // plain random half
        case ($unsigned($random(seed)) % 12)
            0: w[6:0] = OP_JAL;
            1: begin
                w[6:0] = OP_JALR;
                w[14:12] = ($random(seed) & 3) ? 3'd0 : w[14:12];
                if ($random(seed) & 1) w[31:20] = 12'd0;  // ret form
            end
            2: w[6:0] = OP_BRANCH;
            3: w[6:0] = OP_AUIPC;
            4: w[6:0] = ($random(seed) & 1) ? OP_LOAD : OP_LOAD_FP;
            5: w[6:0] = ($random(seed) & 1) ? OP_STORE : OP_STORE_FP;
            6: {w[15:13], w[1:0]} = 5'b101_01;                 // c.j
            7: {w[15:14], w[1:0]} = 4'b11_01;                  // c.beqz/c.bnez
            8: {w[15:12], w[6:0]} = 11'b1000_00000_10;         // c.jr
            9: {w[15:12], w[6:0]} = 11'b1001_00000_10;         // c.jalr
            10: begin
                w[1:0] = 2'b10;              // sp-relative loads/stores
                w[15:13] = $random(seed);
            end
            default: w[1:0] = 2'b00;         // quadrant 0
        endcase
        w[11:7] = pick_reg();
        if (w[1:0] == 2'b11) w[19:15] = pick_reg();
        return w;
    endfunction

    task automatic produce();
        repeat (N_TXN) begin
            while (in_ack) @(negedge clk);
            inst   = make_word();
            in_req = 1'b1;
            do @(negedge clk); while (!in_ack);
            @(negedge clk);                  // in_ack sampled high on a rising edge
            in_req = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic consume();
        int dly;
        while (n_done < N_TXN) begin
            while (!out_req) @(negedge clk);
            dly = $unsigned($random(seed)) % 8;  // back-pressure
            repeat (dly) @(negedge clk);
            out_ack = 1'b1;
            do @(negedge clk); while (out_req);
            repeat ($unsigned($random(seed)) % 3) @(negedge clk);  // late out_ack fall
            out_ack = 1'b0;
            n_done++;
        end
    endtask

    initial begin
        seed    = 32'hefb3;
        n_done  = 0;
        rst_n   = 1'b0;
        in_req  = 1'b0;
        out_ack = 1'b0;
        inst    = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        fork
            produce();
            consume();
        join
        repeat (4) @(negedge clk);
        if (dut0.u_asserts.err_seen) begin
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

    // first assertion failure ends the run
    initial begin
        @(posedge dut0.u_asserts.err_seen);
        $display("Verification failed");
        $fatal(1);
    end

    // watchdog, 40 cycles per instruction plus reset
    initial begin
        #(N_TXN * 40 * 8 + 10 * 8);
        $display("timeout: transactions did not complete in time");
        $display("Verification failed");
        $fatal(1);
    end

endmodule

// File: predecode.f
logic/predecode_pkg.sv
logic/predecode_top.sv
logic/predecode_ctrl.sv
logic/pd_flow_decode.sv
logic/pd_offset_gen.sv
logic/pd_mem_decode.sv
test/predecode_asserts.sv
test/predecode_tb.sv
